/* design/axi_pkg.sv */
package axi_pkg;

	// every transfer on the port is a single 32-bit beat
	localparam int AXI_ADDR_WIDTH = 32;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

	typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
	typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
	typedef logic [1:0]                axi_resp_t;

	// only OKAY and SLVERR are ever returned
	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// write beat as held between the w channel and the bridge
	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
	} w_beat_t;

endpackage

/* design/soc_map_pkg.sv */
package soc_map_pkg;

	// 4 KiB slots, slot number in addr[15:12]
	localparam int SLOT_LSB   = 12;
	localparam int SLOT_WIDTH = 4;

	typedef logic [SLOT_WIDTH-1:0] slot_t;

	localparam slot_t SLOT_LED     = 4'd0;
	localparam slot_t SLOT_SCRATCH = 4'd1;

	// register offsets inside the LED slot
	localparam logic [SLOT_LSB-1:0] LED_SET_OFS    = 12'h000;
	localparam logic [SLOT_LSB-1:0] LED_TOGGLE_OFS = 12'h004;

endpackage

/* design/axi_chan_hold.sv */
`timescale 1ns/1ps

module axi_chan_hold #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	output T     out_data,
	input  logic pop
);

	logic full;
	T     data_q;

	// ready only while the slot is free
	assign in_ready  = !full;
	assign out_valid = full;
	assign out_data  = data_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (in_valid && in_ready) begin
			full <= 1'b1;
		end else if (pop) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

endmodule

/* design/axi_apb_ctrl.sv */
`timescale 1ns/1ps

module axi_apb_ctrl import axi_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// held requests
	input  logic      aw_valid,
	input  axi_addr_t aw_addr,
	output logic      aw_pop,
	input  logic      w_valid,
	input  w_beat_t   w_beat,
	output logic      w_pop,
	input  logic      ar_valid,
	input  axi_addr_t ar_addr,
	output logic      ar_pop,

	// apb master
	output axi_addr_t paddr,
	output logic      pwrite,
	output axi_data_t pwdata,
	output axi_strb_t pstrb,
	output logic      psel,
	output logic      penable,
	input  axi_data_t prdata,
	input  logic      pslverr,

	// axi responses
	output logic      bvalid,
	output axi_resp_t bresp,
	input  logic      bready,
	output logic      rvalid,
	output axi_data_t rdata,
	output axi_resp_t rresp,
	input  logic      rready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SETUP,
		S_ACCESS,
		S_RESP
	} state_t;

	state_t    state;
	logic      cur_write;
	logic      prefer_rd;
	logic      wr_req;
	logic      rd_req;
	logic      wr_go;
	logic      rd_go;
	axi_resp_t resp_q;
	axi_data_t rdata_q;

	// a write needs both its address and its data
	assign wr_req = aw_valid && w_valid;
	assign rd_req = ar_valid;

	// take turns when both sides are waiting
	assign wr_go = wr_req && !(rd_req && prefer_rd);
	assign rd_go = rd_req && !wr_go;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			cur_write <= 1'b0;
			prefer_rd <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (wr_go || rd_go) begin
						state     <= S_SETUP;
						cur_write <= wr_go;
						prefer_rd <= wr_go;
					end
				end
				S_SETUP: begin
					state <= S_ACCESS;
				end
				S_ACCESS: begin
					state <= S_RESP;
				end
				S_RESP: begin
					// hold the response until the master takes it
					if (cur_write ? bready : rready) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// slaves finish in one access cycle, sample there
	always_ff @(posedge clk) begin
		if (state == S_ACCESS) begin
			resp_q <= pslverr ? RESP_SLVERR : RESP_OKAY;
			if (!cur_write) begin
				rdata_q <= prdata;
			end
		end
	end

	assign psel    = (state == S_SETUP) || (state == S_ACCESS);
	assign penable = (state == S_ACCESS);
	assign pwrite  = cur_write;
	assign paddr   = cur_write ? aw_addr : ar_addr;
	assign pwdata  = w_beat.data;
	assign pstrb   = w_beat.strb;

	// release the held entries as the access completes
	assign aw_pop = penable && cur_write;
	assign w_pop  = penable && cur_write;
	assign ar_pop = penable && !cur_write;

	assign bvalid = (state == S_RESP) && cur_write;
	assign bresp  = resp_q;
	assign rvalid = (state == S_RESP) && !cur_write;
	assign rresp  = resp_q;
	assign rdata  = rdata_q;

endmodule

/* design/apb_decoder.sv */
`timescale 1ns/1ps

module apb_decoder import axi_pkg::*, soc_map_pkg::*; (
	input  axi_addr_t paddr,
	input  logic      psel,
	output logic      psel_led,
	output logic      psel_scratch,
	input  axi_data_t prdata_led,
	input  axi_data_t prdata_scratch,
	output axi_data_t prdata,
	output logic      pslverr
);

	slot_t slot;
	logic  hit_led;
	logic  hit_scratch;

	// bits above the slot field are not decoded
	assign slot        = paddr[SLOT_LSB +: SLOT_WIDTH];
	assign hit_led     = (slot == SLOT_LED);
	assign hit_scratch = (slot == SLOT_SCRATCH);

	assign psel_led     = psel && hit_led;
	assign psel_scratch = psel && hit_scratch;

	// nothing answers in the other slots
	assign pslverr = psel && !hit_led && !hit_scratch;

	always_comb begin
		case (slot)
			SLOT_LED: begin
				prdata = prdata_led;
			end
			SLOT_SCRATCH: begin
				prdata = prdata_scratch;
			end
			default: begin
				prdata = '0;
			end
		endcase
	end

endmodule

/* design/led_regs.sv */
`timescale 1ns/1ps

module led_regs import axi_pkg::*, soc_map_pkg::*; #(
	parameter int LED_COUNT = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  axi_addr_t            paddr,
	input  axi_data_t            pwdata,
	input  axi_strb_t            pstrb,
	output axi_data_t            prdata,
	output logic [LED_COUNT-1:0] led
);

	logic [SLOT_LSB-1:0]  ofs;
	logic                 wr_en;
	logic [LED_COUNT-1:0] led_q;

	assign ofs   = paddr[SLOT_LSB-1:0];
	// only byte lane 0 carries the led bits
	assign wr_en = psel && penable && pwrite && pstrb[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_q <= '0;
		end else if (wr_en) begin
			if (ofs == LED_SET_OFS) begin
				led_q <= pwdata[LED_COUNT-1:0];
			end else if (ofs == LED_TOGGLE_OFS) begin
				led_q <= led_q ^ pwdata[LED_COUNT-1:0];
			end
		end
	end

	// toggle register reads back as zero
	always_comb begin
		prdata = '0;
		if (ofs == LED_SET_OFS) begin
			prdata[LED_COUNT-1:0] = led_q;
		end
	end

	assign led = led_q;

endmodule

/* design/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram import axi_pkg::*; #(
	parameter int SCRATCH_WORDS = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  axi_addr_t paddr,
	input  axi_data_t pwdata,
	input  axi_strb_t pstrb,
	output axi_data_t prdata
);

	localparam int IDX_WIDTH = $clog2(SCRATCH_WORDS);

	axi_data_t            mem [SCRATCH_WORDS];
	logic [IDX_WIDTH-1:0] idx;
	logic                 wr_en;

	// word index, higher address bits alias
	assign idx   = paddr[2 +: IDX_WIDTH];
	assign wr_en = psel && penable && pwrite;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SCRATCH_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			for (int b = 0; b < AXI_STRB_WIDTH; b++) begin
				if (pstrb[b]) begin
					mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
				end
			end
		end
	end

	assign prdata = mem[idx];

endmodule

/* design/soc_periph_top.sv */
`timescale 1ns/1ps

module soc_periph_top import axi_pkg::*; #(
	parameter int LED_COUNT     = 4,
	parameter int SCRATCH_WORDS = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 awvalid,
	output logic                 awready,
	input  axi_addr_t            awaddr,
	input  logic                 wvalid,
	output logic                 wready,
	input  axi_data_t            wdata,
	input  axi_strb_t            wstrb,
	output logic                 bvalid,
	input  logic                 bready,
	output axi_resp_t            bresp,
	input  logic                 arvalid,
	output logic                 arready,
	input  axi_addr_t            araddr,
	output logic                 rvalid,
	input  logic                 rready,
	output axi_data_t            rdata,
	output axi_resp_t            rresp,

	output logic [LED_COUNT-1:0] led
);

	// held requests
	w_beat_t   w_in;
	logic      aw_valid;
	axi_addr_t aw_addr;
	logic      aw_pop;
	logic      w_valid;
	w_beat_t   w_beat;
	logic      w_pop;
	logic      ar_valid;
	axi_addr_t ar_addr;
	logic      ar_pop;

	// apb side
	axi_addr_t paddr;
	logic      pwrite;
	axi_data_t pwdata;
	axi_strb_t pstrb;
	logic      psel;
	logic      penable;
	axi_data_t prdata;
	logic      pslverr;
	logic      psel_led;
	logic      psel_scratch;
	axi_data_t prdata_led;
	axi_data_t prdata_scratch;

	assign w_in = '{data: wdata, strb: wstrb};

	axi_chan_hold #(.T(axi_addr_t)) aw_hold_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (awvalid),
		.in_ready  (awready),
		.in_data   (awaddr),
		.out_valid (aw_valid),
		.out_data  (aw_addr),
		.pop       (aw_pop)
	);

	axi_chan_hold #(.T(w_beat_t)) w_hold_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (wvalid),
		.in_ready  (wready),
		.in_data   (w_in),
		.out_valid (w_valid),
		.out_data  (w_beat),
		.pop       (w_pop)
	);

	axi_chan_hold #(.T(axi_addr_t)) ar_hold_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (arvalid),
		.in_ready  (arready),
		.in_data   (araddr),
		.out_valid (ar_valid),
		.out_data  (ar_addr),
		.pop       (ar_pop)
	);

	axi_apb_ctrl ctrl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.aw_valid (aw_valid),
		.aw_addr  (aw_addr),
		.aw_pop   (aw_pop),
		.w_valid  (w_valid),
		.w_beat   (w_beat),
		.w_pop    (w_pop),
		.ar_valid (ar_valid),
		.ar_addr  (ar_addr),
		.ar_pop   (ar_pop),
		.paddr    (paddr),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.pstrb    (pstrb),
		.psel     (psel),
		.penable  (penable),
		.prdata   (prdata),
		.pslverr  (pslverr),
		.bvalid   (bvalid),
		.bresp    (bresp),
		.bready   (bready),
		.rvalid   (rvalid),
		.rdata    (rdata),
		.rresp    (rresp),
		.rready   (rready)
	);

	apb_decoder dec_i (
		.paddr          (paddr),
		.psel           (psel),
		.psel_led       (psel_led),
		.psel_scratch   (psel_scratch),
		.prdata_led     (prdata_led),
		.prdata_scratch (prdata_scratch),
		.prdata         (prdata),
		.pslverr        (pslverr)
	);

	led_regs #(.LED_COUNT(LED_COUNT)) led_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel_led),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata_led),
		.led     (led)
	);

	scratch_ram #(.SCRATCH_WORDS(SCRATCH_WORDS)) scratch_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel_scratch),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata_scratch)
	);

endmodule

/* verif/soc_periph_assertions.sv */
`timescale 1ns/1ps

module soc_periph_assertions import axi_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      psel,
	input logic      penable,
	input logic      bvalid,
	input logic      bready,
	input axi_resp_t bresp,
	input logic      rvalid,
	input logic      rready,
	input axi_data_t rdata
);

	// a pending response waits unchanged for its ready
	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid dropped or bresp changed before bready");

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid dropped or rdata changed before rready");

	// access phase only right after a setup cycle
	apb_phase: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> $past(psel) && !$past(penable))
		else $error("penable without a preceding setup cycle");

	reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> !bvalid && !rvalid)
		else $error("response valid right after reset release");

endmodule

/* verif/tb_soc_periph.sv */
`timescale 1ns/1ps

module tb_soc_periph import axi_pkg::*, soc_map_pkg::*; ();

	localparam int LED_COUNT     = 4;
	localparam int SCRATCH_WORDS = 8;
	localparam int IDX_W         = $clog2(SCRATCH_WORDS);
	localparam int NUM_TXN       = 300;
	localparam int RESET_CYCLES  = 10;
	// each transaction stays well inside 20 cycles
	localparam int CYCLE_LIMIT   = NUM_TXN * 20 + RESET_CYCLES + 200;

	logic                 clk;
	logic                 rst_n;
	logic                 awvalid;
	logic                 awready;
	axi_addr_t            awaddr;
	logic                 wvalid;
	logic                 wready;
	axi_data_t            wdata;
	axi_strb_t            wstrb;
	logic                 bvalid;
	logic                 bready;
	axi_resp_t            bresp;
	logic                 arvalid;
	logic                 arready;
	axi_addr_t            araddr;
	logic                 rvalid;
	logic                 rready;
	axi_data_t            rdata;
	axi_resp_t            rresp;
	logic [LED_COUNT-1:0] led;

	// reference model state
	logic [LED_COUNT-1:0] led_model;
	axi_data_t            scr_model [SCRATCH_WORDS];

	integer seed;
	int     cycle = 0;
	logic   b_prev = 1'b0;
	logic   r_prev = 1'b0;
	int     b_seen = 0;
	int     r_seen = 0;
	int     n_wr = 0;
	int     n_rd = 0;
	int     err_value = 0;
	int     err_latency = 0;

	soc_periph_top #(
		.LED_COUNT     (LED_COUNT),
		.SCRATCH_WORDS (SCRATCH_WORDS)
	) dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp),
		.led     (led)
	);

	bind soc_periph_top soc_periph_assertions asrt_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata)
	);

	always #20 clk = ~clk;

	// a response counts once, on the cycle its valid rises
	always @(posedge clk) begin
		cycle <= cycle + 1;
		b_prev <= bvalid;
		r_prev <= rvalid;
		if (bvalid && !b_prev) begin
			b_seen <= b_seen + 1;
		end
		if (rvalid && !r_prev) begin
			r_seen <= r_seen + 1;
		end
	end

	// next edge, then 1 ns for driving and sampling
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
			err_value++;
		end
	endtask

	task automatic check_latency(input string what, input int rise, input int cap);
		assert (rise == cap + 3) else begin
			$display("[FAIL] %0t %s latency %0d cycles, expected 3", $time, what, rise - cap);
			err_latency++;
		end
	endtask

	task automatic pick_addr(output axi_addr_t addr);
		integer      r;
		slot_t       slot;
		logic [11:0] ofs;
		r = $random(seed);
		ofs = {r[11:2], 2'b00};
		case (r[15:13])
			3'd0, 3'd1, 3'd2: slot = SLOT_LED;
			3'd3, 3'd4, 3'd5: slot = SLOT_SCRATCH;
			default: begin
				slot = r[19:16];
				if (slot < 4'd2) begin
					slot = slot + 4'd2;
				end
			end
		endcase
		// mostly hit the two real led registers
		if (slot == SLOT_LED && r[21:20] == 2'd0) begin
			ofs = LED_SET_OFS;
		end else if (slot == SLOT_LED && r[21:20] == 2'd1) begin
			ofs = LED_TOGGLE_OFS;
		end
		addr = {16'h0000, slot, ofs};
	endtask

	function automatic axi_resp_t model_write(input axi_addr_t addr, input axi_data_t data,
			input axi_strb_t strb);
		slot_t       slot;
		logic [11:0] ofs;
		int          idx;
		slot = addr[15:12];
		ofs = addr[11:0];
		idx = int'(addr[2 +: IDX_W]);
		if (slot == SLOT_SCRATCH) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					scr_model[idx][8*b +: 8] = data[8*b +: 8];
				end
			end
			return RESP_OKAY;
		end
		if (slot == SLOT_LED) begin
			if (strb[0] && ofs == LED_SET_OFS) begin
				led_model = data[LED_COUNT-1:0];
			end else if (strb[0] && ofs == LED_TOGGLE_OFS) begin
				led_model = led_model ^ data[LED_COUNT-1:0];
			end
			return RESP_OKAY;
		end
		return RESP_SLVERR;
	endfunction

	function automatic void model_read(input axi_addr_t addr, output axi_data_t data,
			output axi_resp_t resp);
		slot_t slot;
		slot = addr[15:12];
		data = '0;
		resp = RESP_OKAY;
		if (slot == SLOT_SCRATCH) begin
			data = scr_model[int'(addr[2 +: IDX_W])];
		end else if (slot == SLOT_LED) begin
			if (addr[11:0] == LED_SET_OFS) begin
				data[LED_COUNT-1:0] = led_model;
			end
		end else begin
			resp = RESP_SLVERR;
		end
	endfunction

	task automatic send_aw(input int dly, input axi_addr_t addr, output int cap);
		logic taken;
		repeat (dly) tick();
		awvalid = 1'b1;
		awaddr = addr;
		taken = 1'b0;
		while (!taken) begin
			taken = awready;
			tick();
		end
		awvalid = 1'b0;
		cap = cycle;
	endtask

	task automatic send_w(input int dly, input axi_data_t data, input axi_strb_t strb,
			output int cap);
		logic taken;
		repeat (dly) tick();
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		taken = 1'b0;
		while (!taken) begin
			taken = wready;
			tick();
		end
		wvalid = 1'b0;
		cap = cycle;
	endtask

	task automatic send_ar(input axi_addr_t addr, output int cap);
		logic taken;
		arvalid = 1'b1;
		araddr = addr;
		taken = 1'b0;
		while (!taken) begin
			taken = arready;
			tick();
		end
		arvalid = 1'b0;
		cap = cycle;
	endtask

	task automatic do_write();
		axi_addr_t addr;
		axi_data_t data;
		axi_strb_t strb;
		axi_resp_t exp_resp;
		axi_resp_t got_resp;
		integer    r;
		int        aw_cap;
		int        w_cap;
		int        stall;
		pick_addr(addr);
		data = $random(seed);
		r = $random(seed);
		strb = r[3:0];
		stall = (r >> 8) & 7;
		// aw and w launched in either order or together
		fork
			send_aw((r >> 4) & 3, addr, aw_cap);
			send_w((r >> 6) & 3, data, strb, w_cap);
		join
		while (!bvalid) tick();
		check_latency("write", cycle, (aw_cap > w_cap) ? aw_cap : w_cap);
		exp_resp = model_write(addr, data, strb);
		got_resp = bresp;
		check_value("bresp", 32'(got_resp), 32'(exp_resp));
		repeat (stall) begin
			tick();
			check_value("bvalid under stall", 32'(bvalid), 32'd1);
			check_value("bresp under stall", 32'(bresp), 32'(got_resp));
		end
		bready = 1'b1;
		tick();
		bready = 1'b0;
		check_value("bvalid after handshake", 32'(bvalid), 32'd0);
		check_value("led", 32'(led), 32'(led_model));
		n_wr++;
	endtask

	task automatic do_read();
		axi_addr_t addr;
		axi_data_t exp_data;
		axi_data_t got_data;
		axi_resp_t exp_resp;
		integer    r;
		int        cap;
		int        stall;
		pick_addr(addr);
		r = $random(seed);
		stall = r & 7;
		send_ar(addr, cap);
		while (!rvalid) tick();
		check_latency("read", cycle, cap);
		model_read(addr, exp_data, exp_resp);
		got_data = rdata;
		check_value("rdata", got_data, exp_data);
		check_value("rresp", 32'(rresp), 32'(exp_resp));
		repeat (stall) begin
			tick();
			check_value("rvalid under stall", 32'(rvalid), 32'd1);
			check_value("rdata under stall", rdata, got_data);
			check_value("rresp under stall", 32'(rresp), 32'(exp_resp));
		end
		rready = 1'b1;
		tick();
		rready = 1'b0;
		check_value("rvalid after handshake", 32'(rvalid), 32'd0);
		n_rd++;
	endtask

	initial begin : stimulus
		integer r;
		seed = 65;
		clk = 1'b0;
		rst_n = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		led_model = '0;
		for (int i = 0; i < SCRATCH_WORDS; i++) begin
			scr_model[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		tick();
		for (int n = 0; n < NUM_TXN; n++) begin
			r = $random(seed);
			if (r[0]) begin
				do_write();
			end else begin
				do_read();
			end
		end
		tick();
		// one response per request, none extra
		check_value("write responses", b_seen, n_wr);
		check_value("read responses", r_seen, n_rd);
		$display("error counts: value %0d, latency %0d", err_value, err_latency);
		if (err_value == 0 && err_latency == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin : watchdog
		while (cycle < CYCLE_LIMIT) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test failures found");
		$finish;
	end

endmodule

/* flist.f */
design/axi_pkg.sv
design/soc_map_pkg.sv
design/axi_chan_hold.sv
design/axi_apb_ctrl.sv
design/apb_decoder.sv
design/led_regs.sv
design/scratch_ram.sv
design/soc_periph_top.sv
verif/soc_periph_assertions.sv
verif/tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_soc_periph

# an assertion stop must not skip the log check
./obj_dir/Vtb_soc_periph > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF 'All tests passed!' "$LOG"; then
	echo "simulation PASSED"
	exit 0
else
	echo "simulation FAILED"
	exit 1
fi
